//--- dv/des_core_props.sv
module des_core_props
	import des_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int latency = 2 * num_rounds + 2;   // decode, rounds, result.

	logic accepted;

	assign accepted = start & ~busy;

	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n) accepted |=> busy)
		else $error("busy did not rise after an accepted start");

	a_latency: assert property (@(posedge clk) disable iff (!rst_n) accepted |-> ##latency done)
		else $error("done did not follow an accepted start at the expected cycle");

	a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
		else $error("done pulsed while busy was low");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done stayed high for more than one cycle");

	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
		else $error("busy stayed high after done");

endmodule

bind des_core des_core_props i_des_core_props (.*);

//--- dv/des_core_tb.sv
module des_core_tb
	import des_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period  = 50;
	localparam int reset_cycles = 8;
	localparam int latency      = 34;   // falling edges from start to done.
	localparam int num_kat      = 5;
	localparam int num_rand     = 20;
	localparam int num_ops      = 2 * num_kat + 2 * num_rand + 1;

	typedef struct packed {
		des_block_t key;
		des_block_t plain;
		des_block_t cipher;
	} kat_t;

	localparam kat_t kat_tbl [num_kat] = '{
		'{64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405},
		'{64'h0000000000000000, 64'h0000000000000000, 64'h8CA64DE9C1B123A7},
		'{64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF, 64'h7359B2163E4EDC58},
		'{64'h3000000000000000, 64'h1000000000000001, 64'h958E6E627A05557B},
		'{64'h1111111111111111, 64'h1111111111111111, 64'hF40379AB9E0EC533}
	};

	logic       clk;
	logic       rst_n;
	logic       start;
	logic       decrypt;
	logic       busy;
	logic       done;
	des_block_t key;
	des_block_t block_in;
	des_block_t block_out;
	int         errors = 0;
	int         checks = 0;

	des_core i_des_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.decrypt   (decrypt),
		.key       (key),
		.block_in  (block_in),
		.busy      (busy),
		.done      (done),
		.block_out (block_out)
	);

	always #half_period clk = ~clk;

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// one block through the core with an optional start while busy.
	task automatic run_block(input des_block_t k, input des_block_t b, input logic dec,
		input logic poke, output des_block_t res);
		int cycles;
		@(negedge clk);
		key      = k;
		block_in = b;
		decrypt  = dec;
		start    = 1'b1;
		@(negedge clk);
		start  = 1'b0;
		cycles = 1;
		while (!done) begin
			compare_value("busy", busy, 1);
			if (poke && cycles == 10) begin
				start    = 1'b1;   // the core is busy so this start is dropped.
				block_in = ~b;
			end
			@(negedge clk);
			start = 1'b0;
			cycles++;
		end
		compare_value("busy", busy, 1);
		compare_value("cycles", cycles, latency);
		res = block_out;
		@(negedge clk);
		compare_value("done", done, 0);
		compare_value("busy", busy, 0);
		compare_value("block_out", block_out, res);
	endtask

	// ********************
	// tests
	// ********************

	initial begin
		des_block_t res;
		des_block_t plain;
		des_block_t rkey;
		clk      = 1'b0;
		rst_n    = 1'b0;
		start    = 1'b0;
		decrypt  = 1'b0;
		key      = '0;
		block_in = '0;
		void'($urandom(32'h17ebb3b0));
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		compare_value("block_out", block_out, 0);
		compare_value("busy", busy, 0);
		compare_value("done", done, 0);
		for (int i = 0; i < num_kat; i++) begin
			run_block(kat_tbl[i].key, kat_tbl[i].plain, 1'b0, 1'b0, res);
			compare_value("block_out", res, kat_tbl[i].cipher);
		end
		for (int i = 0; i < num_kat; i++) begin
			run_block(kat_tbl[i].key, kat_tbl[i].cipher, 1'b1, 1'b0, res);
			compare_value("block_out", res, kat_tbl[i].plain);
		end
		for (int i = 0; i < num_rand; i++) begin
			rkey  = {$urandom, $urandom};
			plain = {$urandom, $urandom};
			run_block(rkey, plain, 1'b0, 1'b0, res);
			run_block(rkey, res, 1'b1, 1'b0, res);
			compare_value("block_out", res, plain);
		end
		run_block(kat_tbl[0].key, kat_tbl[0].plain, 1'b0, 1'b1, res);
		compare_value("block_out", res, kat_tbl[0].cipher);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin : watchdog
		#(2 * half_period * (num_ops * 40 + reset_cycles));
		$display("timeout: the DUT did not finish all blocks in time");
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Errors found");
		$finish;
	end

endmodule

//--- logic/des_core.sv
module des_core
	import des_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       decrypt,
	input  des_block_t key,
	input  des_block_t block_in,
	output logic       busy,
	output logic       done,
	output des_block_t block_out
);

	logic         load;
	logic         fin;
	round_state_t state;
	des_block_t   pre_out;

	des_input_decode i_des_input_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.decrypt  (decrypt),
		.key      (key),
		.block_in (block_in),
		.done     (done),
		.busy     (busy),
		.load     (load),
		.state    (state)
	);

	des_round_engine i_des_round_engine (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.state   (state),
		.fin     (fin),
		.pre_out (pre_out)
	);

	des_output_stage i_des_output_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.fin       (fin),
		.pre_out   (pre_out),
		.block_out (block_out),
		.done      (done)
	);

endmodule

//--- logic/des_input_decode.sv
module des_input_decode
	import des_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  logic         decrypt,
	input  des_block_t   key,
	input  des_block_t   block_in,
	input  logic         done,
	output logic         busy,
	output logic         load,
	output round_state_t state
);

	logic        accept;
	des_block_t  ip_blk;
	logic [55:0] pc1_key;

	assign accept = start & ~busy;   // a start while busy is dropped.

	always_comb begin
		for (int j = 0; j < 64; j++) begin
			ip_blk[63 - j] = block_in[64 - ip_tbl[j]];
		end
		for (int j = 0; j < 56; j++) begin
			pc1_key[55 - j] = key[64 - pc1_tbl[j]];   // parity bits fall out here.
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			load <= 1'b0;
		end else begin
			load <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			state.left    <= ip_blk[63:32];
			state.right   <= ip_blk[31:0];
			state.c       <= pc1_key[55:28];
			state.d       <= pc1_key[27:0];
			state.decrypt <= decrypt;
		end
	end

endmodule

//--- logic/des_output_stage.sv
module des_output_stage
	import des_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       fin,
	input  des_block_t pre_out,
	output des_block_t block_out,
	output logic       done
);

	des_block_t fp_blk;

	always_comb begin
		for (int j = 0; j < 64; j++) begin
			fp_blk[63 - j] = pre_out[64 - fp_tbl[j]];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			block_out <= '0;
			done      <= 1'b0;
		end else begin
			done <= fin;   // done follows the fin strobe by one cycle.
			if (fin) begin
				block_out <= fp_blk;   // held until the next result.
			end
		end
	end

endmodule

//--- logic/des_pkg.sv
package des_pkg;

	// ********************
	// data types
	// ********************

	typedef logic [63:0] des_block_t;
	typedef logic [31:0] half_t;
	typedef logic [27:0] key_half_t;
	typedef logic [47:0] subkey_t;

	typedef struct packed {
		logic       outer_hi;   // row msb.
		logic [3:0] column;
		logic       outer_lo;   // row lsb.
	} sbox_addr_t;

	typedef union packed {
		logic [5:0] raw;        // six bits after key mixing.
		sbox_addr_t addr;
	} sbox_in_u;

	typedef sbox_in_u [0:7] sbox_vec_t;   // element 0 is box 1.

	typedef struct packed {
		half_t     left;
		half_t     right;
		key_half_t c;
		key_half_t d;
		logic      decrypt;
	} round_state_t;

	localparam int num_rounds = 16;

	// ********************
	// bit selections in DES numbering
	// ********************

	localparam int ip_tbl [64] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int fp_tbl [64] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
	};

	localparam int e_tbl [48] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
	};

	localparam int p_tbl [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
	};

	localparam int pc1_tbl [56] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};

	localparam int pc2_tbl [48] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	localparam int shift_tbl [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	// ********************
	// substitution boxes by box, row and column
	// ********************

	localparam logic [3:0] sbox_tbl [8][4][16] = '{
		'{'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
		  '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
		  '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
		  '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}},
		'{'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
		  '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
		  '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
		  '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}},
		'{'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
		  '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
		  '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
		  '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}},
		'{'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
		  '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
		  '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
		  '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}},
		'{'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
		  '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
		  '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
		  '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}},
		'{'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
		  '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
		  '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
		  '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}},
		'{'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
		  '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
		  '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
		  '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}},
		'{'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
		  '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
		  '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
		  '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}}
	};

endpackage

//--- logic/des_round_engine.sv
module des_round_engine
	import des_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         load,
	input  round_state_t state,
	output logic         fin,
	output des_block_t   pre_out
);

	logic        active;
	logic        phase_b;
	logic [3:0]  round;
	logic [3:0]  round_nxt;
	logic [3:0]  dec_idx;
	logic        dec;
	logic        last_round;
	half_t       l_half;
	half_t       r_half;
	half_t       r_nxt;
	half_t       p_out;
	key_half_t   c_half;
	key_half_t   d_half;
	logic [55:0] cd;
	logic [47:0] e_r;
	logic [47:0] mix;
	subkey_t     subkey;
	sbox_vec_t   sbox_in;
	half_t       sbox_out;
	int          sh_amt;

	function automatic key_half_t rot_left(key_half_t x, int n);
		return (n == 2) ? {x[25:0], x[27:26]} : {x[26:0], x[27]};
	endfunction

	function automatic key_half_t rot_right(key_half_t x, int n);
		return (n == 2) ? {x[1:0], x[27:2]} : {x[0], x[27:1]};
	endfunction

	des_sbox_bank i_des_sbox_bank (
		.clk      (clk),
		.rst_n    (rst_n),
		.sbox_in  (sbox_in),
		.sbox_out (sbox_out)
	);

	// ********************
	// phase A datapath
	// ********************

	assign cd = {c_half, d_half};

	always_comb begin
		for (int j = 0; j < 48; j++) begin
			e_r[47 - j]    = r_half[32 - e_tbl[j]];
			subkey[47 - j] = cd[56 - pc2_tbl[j]];
		end
		mix = e_r ^ subkey;
		for (int i = 0; i < 8; i++) begin
			sbox_in[i].raw = mix[47 - 6 * i -: 6];
		end
	end

	// ********************
	// phase B datapath
	// ********************

	always_comb begin
		for (int j = 0; j < 32; j++) begin
			p_out[31 - j] = sbox_out[32 - p_tbl[j]];
		end
	end

	assign r_nxt      = l_half ^ p_out;
	assign last_round = active & phase_b & (round == 4'(num_rounds - 1));
	assign fin        = last_round;
	assign pre_out    = {r_nxt, r_half};   // last round skips the swap.

	// rotation that prepares the key halves for the next round.
	assign round_nxt = round + 4'd1;
	assign dec_idx   = 4'(num_rounds - 1) - round;
	assign sh_amt    = dec ? shift_tbl[dec_idx] : shift_tbl[round_nxt];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			phase_b <= 1'b0;
			round   <= '0;
		end else if (load) begin
			active  <= 1'b1;
			phase_b <= 1'b0;
			round   <= '0;
		end else if (active) begin
			phase_b <= ~phase_b;
			if (phase_b) begin
				round <= round_nxt;
				if (last_round) begin
					active <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			l_half <= state.left;
			r_half <= state.right;
			dec    <= state.decrypt;
			c_half <= state.decrypt ? state.c : rot_left(state.c, shift_tbl[0]);
			d_half <= state.decrypt ? state.d : rot_left(state.d, shift_tbl[0]);
		end else if (active && phase_b) begin
			l_half <= r_half;
			r_half <= r_nxt;
			c_half <= dec ? rot_right(c_half, sh_amt) : rot_left(c_half, sh_amt);
			d_half <= dec ? rot_right(d_half, sh_amt) : rot_left(d_half, sh_amt);
		end
	end

endmodule

//--- logic/des_sbox_bank.sv
module des_sbox_bank
	import des_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  sbox_vec_t sbox_in,
	output half_t     sbox_out
);

	half_t look;

	// row from the two outer bits and column from the four inner ones.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			look[31 - 4 * i -: 4] = sbox_tbl[i]
				[{sbox_in[i].addr.outer_hi, sbox_in[i].addr.outer_lo}]
				[sbox_in[i].addr.column];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sbox_out <= '0;
		end else begin
			sbox_out <= look;   // box 1 lands in the top nibble.
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the DES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module des_core_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vdes_core_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "No errors"; then
	exit 0
fi
exit 1

//--- src.f
logic/des_pkg.sv
logic/des_input_decode.sv
logic/des_sbox_bank.sv
logic/des_round_engine.sv
logic/des_output_stage.sv
logic/des_core.sv
dv/des_core_props.sv
dv/des_core_tb.sv
